/* logic/hisBuilderFSM.sv */
`timescale 1ns/1ps
`include "sifhDefs_defs.svh"

module hisBuilderFSM (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               wrEn,
    input  sifhPkg::sampleT                    data,
    input  logic                               busy,
    input  sifhPkg::shiftT                     binShift,
    output logic                               valWrEn,
    output sifhPkg::pixelIdxT                  valAddr,
    output sifhPkg::pixelValT                  valData,
    input  sifhPkg::pixelValT                  valRd0,
    input  sifhPkg::pixelValT                  valRd1,
    input  sifhPkg::pixelValT                  valRd2,
    output logic [`NP*`PIXEL_NUM_PER_RAM-1:0]  result,
    output logic                               incEn,
    output sifhPkg::binAddrT                   incAddr,
    output logic                               acqDone
);
    import sifhPkg::*;

    localparam int       PIX_TOTAL = `RAM_NUM * `PIXEL_NUM_PER_RAM;
    localparam pixelIdxT LAST_PIX  = pixelIdxT'(PIX_TOTAL - 1);
    localparam binIdxT   MAX_BIN   = binIdxT'(`BIN_NUM - 1);

    seqStateT     state;
    pixelIdxT     pixIdx;
    sampleT       firstSample;
    logic         accept;
    logic         pairDone;
    logic [`NP:0] pairSum;
    pixelValT     pairAvg;
    pixelValT     binRaw;
    binIdxT       bin;
    logic         resPend;

    // samples are taken only in First and Second, and never while readout runs
    assign accept   = wrEn && !busy && (state == First || state == Second);
    assign pairDone = accept && (state == Second);

    assign pairSum = {1'b0, firstSample} + {1'b0, data};
    assign pairAvg = pixelValT'(pairSum >> 1);

    // large values pile up in the top bin
    assign binRaw = pairAvg >> binShift;
    assign bin    = (binRaw > pixelValT'(MAX_BIN)) ? MAX_BIN : binIdxT'(binRaw);

    // after the last pair Hold and Idle drop samples for two cycles,
    // giving readout time to see acqDone and raise busy
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= Idle;
            pixIdx  <= '0;
            acqDone <= 1'b0;
        end else begin
            acqDone <= 1'b0;
            case (state)
                Idle: begin
                    state <= First;
                end
                First: begin
                    if (accept) begin
                        state <= Second;
                    end
                end
                Second: begin
                    if (accept) begin
                        if (pixIdx == LAST_PIX) begin
                            pixIdx <= '0;
                            state  <= Hold;
                        end else begin
                            pixIdx <= pixIdx + 1'b1;
                            state  <= First;
                        end
                    end
                end
                Hold: begin
                    acqDone <= 1'b1;
                    state   <= Idle;
                end
                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept && state == First) begin
            firstSample <= data;
        end
    end

    // value write and count increment leave together, result follows one cycle
    // after the value has landed in the store
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            valWrEn <= 1'b0;
            incEn   <= 1'b0;
            resPend <= 1'b0;
            valAddr <= '0;
            result  <= '0;
        end else begin
            valWrEn <= pairDone;
            incEn   <= pairDone;
            resPend <= valWrEn;
            if (pairDone) begin
                valAddr <= pixIdx;
            end
            if (resPend) begin
                result <= {valRd2, valRd1, valRd0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pairDone) begin
            valData <= pairAvg;
            incAddr <= binAddrT'(pixIdx * `BIN_NUM + bin);
        end
    end

    // readout may only start while the builder waits for the first sample of a new acquisition
    readoutAtBoundary: assert property (@(posedge clk) disable iff (!rstN)
        $rose(busy) |-> (state == First && pixIdx == '0))
        else $error("hisBuilderFSM: readout started inside an acquisition");

endmodule

/* logic/histConfig.sv */
`timescale 1ns/1ps

module histConfig (
    input  logic             clk,
    input  logic             rstN,
    input  logic             cfgWrEn,
    input  logic             cfgAddr,
    input  sifhPkg::acqCntT  cfgData,
    output sifhPkg::shiftT   binShift,
    output sifhPkg::acqCntT  acqTarget
);
    import sifhPkg::*;

    localparam shiftT  SHIFT_RST  = 4'd7;
    localparam acqCntT TARGET_RST = 8'd2;

    localparam logic ADDR_SHIFT  = 1'b0;
    localparam logic ADDR_TARGET = 1'b1;

    // a new shift may land in the middle of an acquisition and simply
    // applies to the pixels that follow it
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            binShift  <= SHIFT_RST;
            acqTarget <= TARGET_RST;
        end else if (cfgWrEn) begin
            case (cfgAddr)
                ADDR_SHIFT: begin
                    binShift <= shiftT'(cfgData);
                end
                ADDR_TARGET: begin
                    acqTarget <= cfgData;
                end
                default: begin
                    binShift <= binShift;
                end
            endcase
        end
    end

endmodule

/* logic/histReadout.sv */
`timescale 1ns/1ps
`include "sifhDefs_defs.svh"

module histReadout (
    input  logic               clk,
    input  logic               rstN,
    input  logic               acqDone,
    input  sifhPkg::acqCntT    acqTarget,
    output logic               busy,
    output sifhPkg::binAddrT   rdAddr,
    input  sifhPkg::binCountT  rdData,
    output logic               clrEn,
    output sifhPkg::binAddrT   clrAddr,
    output logic               rdValid,
    output sifhPkg::pixelIdxT  rdPixel,
    output sifhPkg::binIdxT    rdBin,
    output sifhPkg::binCountT  rdCount
);
    import sifhPkg::*;

    localparam int      BIN_W     = $clog2(`BIN_NUM);
    localparam binAddrT LAST_ADDR = binAddrT'(`BIN_NUM * `RAM_NUM * `PIXEL_NUM_PER_RAM - 1);

    acqCntT acqCnt;
    logic   reading;
    logic   targetHit;

    // a zero target behaves like one
    assign targetHit = ({1'b0, acqCnt} + 9'd1) >= {1'b0, acqTarget};

    // every address is cleared in the same cycle it is read
    assign clrEn   = reading;
    assign clrAddr = rdAddr;

    // busy covers the whole sweep plus the cycle of the last output word
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            acqCnt  <= '0;
            busy    <= 1'b0;
            reading <= 1'b0;
            rdAddr  <= '0;
            rdValid <= 1'b0;
        end else begin
            rdValid <= reading;
            if (!busy) begin
                if (acqDone) begin
                    if (targetHit) begin
                        busy    <= 1'b1;
                        reading <= 1'b1;
                        rdAddr  <= '0;
                    end else begin
                        acqCnt <= acqCnt + 1'b1;
                    end
                end
            end else if (reading) begin
                if (rdAddr == LAST_ADDR) begin
                    reading <= 1'b0;
                end else begin
                    rdAddr <= rdAddr + 1'b1;
                end
            end else if (rdValid) begin
                busy   <= 1'b0;
                acqCnt <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reading) begin
            rdCount <= rdData;
            rdPixel <= pixelIdxT'(rdAddr >> BIN_W);
            rdBin   <= binIdxT'(rdAddr);
        end
    end

endmodule

/* logic/histStore.sv */
`timescale 1ns/1ps

module histStore #(
    parameter type payloadT = logic [7:0],
    parameter int  DEPTH    = 8,
    parameter int  RD_PORTS = 1,
    localparam int AW       = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic [RD_PORTS-1:0][AW-1:0]  rdAddr,
    output payloadT [RD_PORTS-1:0]       rdData,
    input  logic                         wrEn,
    input  logic [AW-1:0]                wrAddr,
    input  payloadT                      wrData,
    input  logic                         incEn,
    input  logic [AW-1:0]                incAddr
);

    payloadT       mem [DEPTH];
    logic          incPend;
    logic [AW-1:0] incPendAddr;
    payloadT       incPendVal;

    always_comb begin
        for (int i = 0; i < RD_PORTS; i++) begin
            rdData[i] = mem[rdAddr[i]];
        end
    end

    // increment is read-modify-write: the old value is captured now and
    // written back plus one on the next edge
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            incPend <= 1'b0;
        end else begin
            incPend <= incEn;
        end
    end

    always_ff @(posedge clk) begin
        if (incEn) begin
            incPendAddr <= incAddr;
            incPendVal  <= mem[incAddr];
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (wrEn) begin
                mem[wrAddr] <= wrData;
            end
            if (incPend) begin
                mem[incPendAddr] <= payloadT'(incPendVal + 1'b1);
            end
        end
    end

    // a closer increment would read the value before the previous write-back
    incSpacing: assert property (@(posedge clk) disable iff (!rstN) incEn |=> !incEn)
        else $error("histStore: increments less than two cycles apart");

    wrIncClash: assert property (@(posedge clk) disable iff (!rstN)
        (wrEn && incPend) |-> (wrAddr != incPendAddr))
        else $error("histStore: write and increment hit the same address");

endmodule

/* logic/sifhDefs_defs.svh */
`ifndef SIFH_DEFS_SVH
`define SIFH_DEFS_SVH

// width of one raw sample and of an averaged pixel value
`define NP 10

// pixels held by one group of the front end
`define PIXEL_NUM_PER_RAM 3

// groups delivered per acquisition
`define RAM_NUM 2

// histogram bins kept for every pixel
`define BIN_NUM 8

// width of one bin counter
`define CNT_W 12

`endif

/* logic/sifhHistTop.sv */
`timescale 1ns/1ps
`include "sifhDefs_defs.svh"

module sifhHistTop (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               wrEn,
    input  sifhPkg::sampleT                    data,
    input  logic                               cfgWrEn,
    input  logic                               cfgAddr,
    input  sifhPkg::acqCntT                    cfgData,
    output logic [`NP*`PIXEL_NUM_PER_RAM-1:0]  result,
    output logic                               busy,
    output logic                               rdValid,
    output sifhPkg::pixelIdxT                  rdPixel,
    output sifhPkg::binIdxT                    rdBin,
    output sifhPkg::binCountT                  rdCount
);
    import sifhPkg::*;

    localparam int PIX_TOTAL = `RAM_NUM * `PIXEL_NUM_PER_RAM;
    localparam int CNT_DEPTH = PIX_TOTAL * `BIN_NUM;

    shiftT    binShift;
    acqCntT   acqTarget;
    logic     valWrEn;
    pixelIdxT valAddr;
    pixelValT valData;
    pixelIdxT groupBase;
    logic     incEn;
    binAddrT  incAddr;
    logic     acqDone;
    binAddrT  cntRdAddr;
    binCountT cntRdData;
    logic     clrEn;
    binAddrT  clrAddr;

    logic [`PIXEL_NUM_PER_RAM-1:0][$bits(pixelIdxT)-1:0] valRdAddr;
    pixelValT [`PIXEL_NUM_PER_RAM-1:0]                   valRd;

    // the result bus shows the whole group of the pixel written last
    assign groupBase = pixelIdxT'((valAddr / `PIXEL_NUM_PER_RAM) * `PIXEL_NUM_PER_RAM);

    always_comb begin
        for (int i = 0; i < `PIXEL_NUM_PER_RAM; i++) begin
            valRdAddr[i] = groupBase + pixelIdxT'(i);
        end
    end

    histConfig config0 (
        .clk(clk), .rstN(rstN), .cfgWrEn(cfgWrEn), .cfgAddr(cfgAddr),
        .cfgData(cfgData), .binShift(binShift), .acqTarget(acqTarget)
    );

    hisBuilderFSM builder (
        .clk(clk), .rstN(rstN), .wrEn(wrEn), .data(data), .busy(busy),
        .binShift(binShift), .valWrEn(valWrEn), .valAddr(valAddr), .valData(valData),
        .valRd0(valRd[0]), .valRd1(valRd[1]), .valRd2(valRd[2]), .result(result),
        .incEn(incEn), .incAddr(incAddr), .acqDone(acqDone)
    );

    histReadout readout (
        .clk(clk), .rstN(rstN), .acqDone(acqDone), .acqTarget(acqTarget), .busy(busy),
        .rdAddr(cntRdAddr), .rdData(cntRdData), .clrEn(clrEn), .clrAddr(clrAddr),
        .rdValid(rdValid), .rdPixel(rdPixel), .rdBin(rdBin), .rdCount(rdCount)
    );

    // readout clears through the write port, the builder counts through increments
    histStore #(.payloadT(binCountT), .DEPTH(CNT_DEPTH), .RD_PORTS(1)) countStore (
        .clk(clk), .rstN(rstN), .rdAddr(cntRdAddr), .rdData(cntRdData),
        .wrEn(clrEn), .wrAddr(clrAddr), .wrData('0), .incEn(incEn), .incAddr(incAddr)
    );

    histStore #(.payloadT(pixelValT), .DEPTH(PIX_TOTAL), .RD_PORTS(`PIXEL_NUM_PER_RAM)) valueStore (
        .clk(clk), .rstN(rstN), .rdAddr(valRdAddr), .rdData(valRd),
        .wrEn(valWrEn), .wrAddr(valAddr), .wrData(valData), .incEn(1'b0), .incAddr('0)
    );

endmodule

/* logic/sifhPkg.sv */
`include "sifhDefs_defs.svh"

package sifhPkg;

    // raw sample as it arrives on the input stream
    typedef logic [`NP-1:0] sampleT;

    // pair average of one pixel
    typedef logic [`NP-1:0] pixelValT;

    // pixel index over all groups of an acquisition
    typedef logic [$clog2(`RAM_NUM * `PIXEL_NUM_PER_RAM)-1:0] pixelIdxT;

    typedef logic [$clog2(`BIN_NUM)-1:0] binIdxT;

    typedef logic [`CNT_W-1:0] binCountT;

    // pixel times bin count plus bin
    typedef logic [$bits(pixelIdxT) + $bits(binIdxT)-1:0] binAddrT;

    typedef logic [3:0] shiftT;

    typedef logic [7:0] acqCntT;

    // builder sequencing: First and Second take the two samples of a pixel,
    // Hold closes an acquisition
    typedef enum logic [1:0] {
        Idle,
        First,
        Second,
        Hold
    } seqStateT;

endpackage

/* sifhHist.f */
+incdir+logic
logic/sifhPkg.sv
logic/histConfig.sv
logic/histStore.sv
logic/hisBuilderFSM.sv
logic/histReadout.sv
logic/sifhHistTop.sv
sim/histChecker.sv
sim/sifhHistTb.sv

/* sim/histChecker.sv */
`timescale 1ns/1ps
`include "sifhDefs_defs.svh"

module histChecker (
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               wrEn,
    input  sifhPkg::sampleT                    data,
    input  logic                               cfgWrEn,
    input  logic                               cfgAddr,
    input  sifhPkg::acqCntT                    cfgData,
    input  logic [`NP*`PIXEL_NUM_PER_RAM-1:0]  result,
    input  logic                               busy,
    input  logic                               rdValid,
    input  sifhPkg::pixelIdxT                  rdPixel,
    input  sifhPkg::binIdxT                    rdBin,
    input  sifhPkg::binCountT                  rdCount,
    input  logic [95:0]                        testName,
    input  logic                               testDone,
    output int                                 errorCount,
    output int                                 testsRun,
    output int                                 testsFailed
);
    import sifhPkg::*;

    localparam int PPR     = `PIXEL_NUM_PER_RAM;
    localparam int PIX_ALL = `RAM_NUM * PPR;
    localparam int DEPTH   = PIX_ALL * `BIN_NUM;
    localparam int ACQ_LEN = 2 * PIX_ALL;

    logic [`NP-1:0]     vals [PIX_ALL];
    int                 counts [DEPTH];
    logic [`NP*PPR-1:0] shown;
    logic [`NP*PPR-1:0] expQ [$];
    int                 dueQ [$];
    int                 cycle;
    int                 sampleIdx;
    int                 firstSample;
    int                 shiftNow;
    int                 rdIdx;
    int                 testErrors;
    logic               busyPrev;

    task automatic compareValue(input string what, input int expVal, input int actVal);
        if (expVal != actVal) begin
            errorCount++;
            testErrors++;
            $display("FAILED %0s %0s: expected %0d, actual %0d", testName, what, expVal, actVal);
        end
    endtask

    initial begin
        errorCount  = 0;
        testsRun    = 0;
        testsFailed = 0;
        testErrors  = 0;
        cycle       = 0;
        sampleIdx   = 0;
        firstSample = 0;
        rdIdx       = 0;
        shiftNow    = 7;
        busyPrev    = 1'b0;
        shown       = '0;
        for (int i = 0; i < PIX_ALL; i++) begin
            vals[i] = '0;
        end
        for (int i = 0; i < DEPTH; i++) begin
            counts[i] = 0;
        end
    end

    always @(posedge clk) begin
        int pix;
        int avg;
        int bin;
        logic [`NP*PPR-1:0] grp;
        cycle++;
        if (rstN) begin
            if (wrEn && !busy) begin
                if (sampleIdx % 2 == 0) begin
                    firstSample = data;
                end else begin
                    pix = sampleIdx / 2;
                    avg = (firstSample + data) >> 1;
                    bin = avg >> shiftNow;
                    if (bin > `BIN_NUM - 1) begin
                        bin = `BIN_NUM - 1;
                    end
                    vals[pix] = avg[`NP-1:0];
                    counts[pix * `BIN_NUM + bin]++;
                    for (int i = 0; i < PPR; i++) begin
                        grp[i*`NP +: `NP] = vals[(pix / PPR) * PPR + i];
                    end
                    // the group shows up two edges after its second sample
                    expQ.push_back(grp);
                    dueQ.push_back(cycle + 2);
                end
                sampleIdx = (sampleIdx + 1) % ACQ_LEN;
            end
            if (rdValid && rdIdx >= DEPTH) begin
                errorCount++;
                testErrors++;
                $display("test %0s: readout gave a word past the last address", testName);
            end else if (rdValid) begin
                compareValue($sformatf("pixel of word %0d", rdIdx), rdIdx / `BIN_NUM, rdPixel);
                compareValue($sformatf("bin of word %0d", rdIdx), rdIdx % `BIN_NUM, rdBin);
                compareValue($sformatf("count of word %0d", rdIdx), counts[rdIdx], rdCount);
                counts[rdIdx] = 0;
                rdIdx++;
            end
            if (busyPrev && !busy) begin
                compareValue("readout word total", DEPTH, rdIdx);
                rdIdx = 0;
            end
            busyPrev = busy;
            if (cfgWrEn && cfgAddr == 1'b0) begin
                shiftNow = cfgData[3:0];
            end
            if (testDone) begin
                // nothing offered during readout may have moved the bus
                compareValue("result held", shown, result);
                testsRun++;
                if (testErrors == 0) begin
                    $display("test %0s: ok", testName);
                end else begin
                    testsFailed++;
                    $display("test %0s: %0d errors", testName, testErrors);
                end
                testErrors = 0;
            end
        end
    end

    always @(negedge clk) begin
        int due;
        if (!rstN) begin
            compareValue("busy in reset", 0, busy);
            compareValue("rdValid in reset", 0, rdValid);
            compareValue("result in reset", 0, result);
        end
        if (dueQ.size() > 0 && dueQ[0] == cycle) begin
            due   = dueQ.pop_front();
            shown = expQ.pop_front();
            compareValue($sformatf("result at cycle %0d", due), shown, result);
        end
    end

endmodule

/* sim/sifhHistTb.sv */
`timescale 1ns/1ps
`include "sifhDefs_defs.svh"

module sifhHistTb;
    import sifhPkg::*;

    localparam int NUM_TESTS = 5;
    localparam int MAX_ACQ   = 3;
    localparam int ACQ_LEN   = 2 * `RAM_NUM * `PIXEL_NUM_PER_RAM;
    localparam int BUSY_WAIT = 200;
    localparam int DROP_LEN  = 6;

    // reference sequences, first sample in the top bits
    localparam logic [ACQ_LEN*`NP-1:0] REF_A = {10'd108, 10'd511, 10'd1023, 10'd1023,
        10'd200, 10'd90, 10'd640, 10'd700, 10'd15, 10'd33, 10'd1000, 10'd980};
    localparam logic [ACQ_LEN*`NP-1:0] REF_B = {10'd300, 10'd500, 10'd50, 10'd70,
        10'd812, 10'd800, 10'd0, 10'd1, 10'd256, 10'd258, 10'd999, 10'd1000};

    logic                              clk;
    logic                              rstN;
    logic                              wrEn;
    sampleT                            data;
    logic                              cfgWrEn;
    logic                              cfgAddr;
    acqCntT                            cfgData;
    logic [`NP*`PIXEL_NUM_PER_RAM-1:0] result;
    logic                              busy;
    logic                              rdValid;
    pixelIdxT                          rdPixel;
    binIdxT                            rdBin;
    binCountT                          rdCount;
    logic [95:0]                       testName;
    logic                              testDone;
    int                                errorCount;
    int                                testsRun;
    int                                testsFailed;
    int                                tbErrors;
    int                                limitCycles;

    logic [95:0] nameTab [NUM_TESTS];
    shiftT       shiftTab [NUM_TESTS];
    acqCntT      targetTab [NUM_TESTS];
    logic        dropTab [NUM_TESTS];
    sampleT      sampleTab [NUM_TESTS][MAX_ACQ][ACQ_LEN];

    sifhHistTop UUT (.*);

    histChecker chk (.*);

    always #5 clk = ~clk;

    task automatic setRow(input int t, input logic [95:0] name, input int shift,
                          input int target, input logic drop);
        nameTab[t]   = name;
        shiftTab[t]  = shiftT'(shift);
        targetTab[t] = acqCntT'(target);
        dropTab[t]   = drop;
    endtask

    task automatic loadAcq(input int t, input int a, input logic [ACQ_LEN*`NP-1:0] row);
        for (int k = 0; k < ACQ_LEN; k++) begin
            sampleTab[t][a][k] = row[(ACQ_LEN-1-k)*`NP +: `NP];
        end
    endtask

    task automatic fillRandom(input int t);
        for (int a = 0; a < MAX_ACQ; a++) begin
            for (int k = 0; k < ACQ_LEN; k++) begin
                sampleTab[t][a][k] = sampleT'($urandom % (1 << `NP));
            end
        end
    endtask

    task automatic writeCfg(input logic addr, input acqCntT value);
        @(negedge clk);
        cfgWrEn = 1'b1;
        cfgAddr = addr;
        cfgData = value;
        @(negedge clk);
        cfgWrEn = 1'b0;
    endtask

    task automatic playAcq(input int t, input int a);
        for (int k = 0; k < ACQ_LEN; k++) begin
            @(negedge clk);
            wrEn = 1'b1;
            data = sampleTab[t][a][k];
        end
        @(negedge clk);
        wrEn = 1'b0;
        // the builder closes the acquisition before it takes samples again
        repeat (3) @(negedge clk);
    endtask

    task automatic offerWhileBusy();
        repeat (DROP_LEN) begin
            @(negedge clk);
            wrEn = 1'b1;
            data = sampleT'($urandom % (1 << `NP));
        end
        @(negedge clk);
        wrEn = 1'b0;
    endtask

    task automatic waitBusy(input logic level);
        int n;
        n = 0;
        while (busy !== level && n < BUSY_WAIT) begin
            @(negedge clk);
            n++;
        end
        if (busy !== level) begin
            tbErrors++;
            $display("test %0s: busy did not go to %0b within %0d cycles", testName, level, n);
        end
    endtask

    task automatic finishTest();
        @(negedge clk);
        testDone = 1'b1;
        @(negedge clk);
        testDone = 1'b0;
    endtask

    initial begin
        int seedInit;
        int total;
        clk         = 1'b0;
        rstN        = 1'b0;
        wrEn        = 1'b0;
        data        = '0;
        cfgWrEn     = 1'b0;
        cfgAddr     = 1'b0;
        cfgData     = '0;
        testName    = "reset";
        testDone    = 1'b0;
        tbErrors    = 0;
        limitCycles = 0;
        seedInit    = $urandom(32'hf37b_c13e);
        setRow(0, "refDefault", 7, 2, 1'b0);
        setRow(1, "refShift4", 4, 1, 1'b0);
        setRow(2, "busyDrop", 5, 1, 1'b1);
        setRow(3, "randomA", 6, 3, 1'b1);
        setRow(4, "randomB", 2, 2, 1'b0);
        loadAcq(0, 0, REF_A);
        loadAcq(0, 1, REF_B);
        loadAcq(1, 0, REF_A);
        loadAcq(2, 0, REF_B);
        fillRandom(3);
        fillRandom(4);
        total = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            total += targetTab[t] * ACQ_LEN + (dropTab[t] ? DROP_LEN : 0) + 60;
        end
        limitCycles = 2 * total;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        finishTest();
        for (int t = 0; t < NUM_TESTS; t++) begin
            testName = nameTab[t];
            writeCfg(1'b0, acqCntT'(shiftTab[t]));
            writeCfg(1'b1, targetTab[t]);
            for (int a = 0; a < targetTab[t]; a++) begin
                playAcq(t, a);
            end
            waitBusy(1'b1);
            if (dropTab[t]) begin
                offerWhileBusy();
            end
            waitBusy(1'b0);
            finishTest();
        end
        @(negedge clk);
        $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed,
                 errorCount + tbErrors);
        if (errorCount + tbErrors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        wait (limitCycles > 0);
        #(limitCycles * 10);
        $display("watchdog: run still going after %0d cycles, stopping it", limitCycles);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule
